// File: source/bch_gf_pkg.sv
`default_nettype none

package bch_gf_pkg;

  // ------------------------------
  // field constants
  // ------------------------------

  // GF(2^m), m = 4
  localparam int gf_m = 4;
  // x^4 + x + 1
  localparam int gf_irrpol = 19;
  // width of an unreduced product
  localparam int gf_pw = 2 * gf_m - 1;

  // one field element, polynomial basis
  typedef logic [gf_m-1:0] data_t;

  // ------------------------------
  // arithmetic
  // ------------------------------

  function automatic data_t gf_mult_a_by_b(input data_t a, input data_t b);
    logic [gf_pw-1:0] prod;
    prod = '0;
    // carry-less product
    for (int i = 0; i < gf_m; i++) begin
      if (b[i]) begin
        prod ^= gf_pw'(a) << i;
      end
    end
    // fold high terms back, top bit first
    for (int i = gf_pw - 1; i >= gf_m; i--) begin
      if (prod[i]) begin
        prod ^= gf_pw'(gf_irrpol) << (i - gf_m);
      end
    end
    return prod[gf_m-1:0];
  endfunction

  // alpha^p, p taken modulo the field order
  function automatic data_t gf_alpha_pow(input int p);
    data_t r;
    r = data_t'(1);
    for (int i = 0; i < p % (2**gf_m - 1); i++) begin
      r = gf_mult_a_by_b(r, data_t'(2));
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: source/bch_dec_pkg.sv
`default_nettype none

package bch_dec_pkg;

  // ------------------------------
  // code constants
  // ------------------------------

  // BCH(15,5), three errors per frame
  localparam int bch_n = 15;
  localparam int bch_t = 3;
  // syndromes S1..S6
  localparam int bch_t2 = 2 * bch_t;
  // frames in flight inside the buffer
  localparam int bch_nslots = 2;

  // frame slot index
  typedef logic [$clog2(bch_nslots)-1:0] ptr_t;

  // error locator, coefficient 0 first
  typedef bch_gf_pkg::data_t loc_poly_t [0:bch_t];

endpackage

`default_nettype wire

// File: source/bch_loc_if.sv
`default_nettype none

interface bch_loc_if;

  import bch_dec_pkg::*;

  // locator handed over, one-cycle strobe
  logic      loc_val;
  loc_poly_t loc_poly;
  // slot holding the received frame
  ptr_t      loc_ptr;
  // input latch freed, credit back to source
  logic      loc_credit;

  modport src (output loc_val, loc_poly, loc_ptr, input loc_credit);
  modport dst (input loc_val, loc_poly, loc_ptr, output loc_credit);

endinterface

`default_nettype wire

// File: source/bch_buf_if.sv
`default_nettype none

interface bch_buf_if #(
  parameter int n = bch_dec_pkg::bch_n
);

  import bch_dec_pkg::*;

  // request side
  logic               req;
  logic               we;
  ptr_t               slot;
  logic [$clog2(n)-1:0] addr;
  logic               wdata;
  // memory side, rdata one cycle after a granted read
  logic               gnt;
  logic               rdata;

  modport requester (output req, we, slot, addr, wdata, input gnt, rdata);
  modport mem (input req, we, slot, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// File: source/bch_syndrome.sv
`default_nettype none

module bch_syndrome #(
  parameter int n = bch_dec_pkg::bch_n,
  parameter int t = bch_dec_pkg::bch_t
) (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              in_val,
  input  logic              in_bit,
  output logic              syn_val,
  output bch_dec_pkg::ptr_t syn_ptr,
  output bch_gf_pkg::data_t syndrome [1:2*t],
  bch_buf_if.requester      wr
);

  import bch_gf_pkg::*;
  import bch_dec_pkg::*;

  localparam int addr_w = $clog2(n);

  // index of incoming bit, highest degree arrives first
  logic [addr_w-1:0] bit_idx;
  ptr_t              wr_slot;
  logic              frame_end;
  logic              frame_start;

  assign frame_start = (bit_idx == addr_w'(n - 1));
  assign frame_end   = in_val && (bit_idx == '0);

  // ------------------------------
  // buffer writes
  // ------------------------------

  // bit index doubles as the buffer address
  assign wr.req   = in_val;
  assign wr.we    = 1'b1;
  assign wr.slot  = wr_slot;
  assign wr.addr  = bit_idx;
  assign wr.wdata = in_bit;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      bit_idx <= addr_w'(n - 1);
      wr_slot <= '0;
      syn_val <= 1'b0;
      syn_ptr <= '0;
    end else begin
      syn_val <= frame_end;
      if (in_val) begin
        bit_idx <= frame_end ? addr_w'(n - 1) : bit_idx - 1'b1;
      end
      // hand slot over, move to the other one
      if (frame_end) begin
        syn_ptr <= wr_slot;
        wr_slot <= wr_slot + 1'b1;
      end
    end
  end

  // ------------------------------
  // horner accumulation
  // ------------------------------

  // S_j = S_j * alpha^j + r_i on every beat
  always_ff @(posedge iclk) begin
    if (in_val) begin
      for (int j = 1; j <= 2 * t; j++) begin
        if (frame_start) begin
          syndrome[j] <= data_t'(in_bit);
        end else begin
          syndrome[j] <= gf_mult_a_by_b(syndrome[j], gf_alpha_pow(j)) ^ data_t'(in_bit);
        end
      end
    end
  end

  // input has no stall path, buffer must always take the write
  a_wr_never_denied : assert property (@(posedge iclk) disable iff (ireset)
    wr.req |-> wr.gnt);

endmodule

`default_nettype wire

// File: source/bch_berlekamp_ibm_2t.sv
`default_nettype none

module bch_berlekamp_ibm_2t #(
  parameter int m = bch_gf_pkg::gf_m,
  parameter int t = bch_dec_pkg::bch_t
) (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              syn_val,
  input  bch_dec_pkg::ptr_t syn_ptr,
  input  bch_gf_pkg::data_t syndrome [1:2*t],
  bch_loc_if.src            loc
);

  import bch_gf_pkg::*;
  import bch_dec_pkg::*;

  localparam int cnt_w = $clog2(t + 1);

  typedef enum logic [2:0] {
    s_reset,
    s_wait,
    s_step1,
    s_step2,
    s_hold
  } state_t;

  state_t state;

  // syndromes padded with zeros below S1, shifted by two per iteration
  data_t syn_reg [1-t:2*t];
  ptr_t  lat_ptr;

  // lambda and B, low guard taps stay zero
  data_t l_poly      [-1:t];
  data_t l_poly_next [0:t];
  data_t b_poly      [-2:t];

  data_t mult [0:t];
  data_t delta_c;
  data_t delta;
  data_t sigma;
  logic [m-1:0] kv;

  logic [cnt_w-1:0] cnt;
  logic             cnt_done;
  // credit for the chien input latch
  logic [1:0]       credit;

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= s_reset;
      cnt      <= '0;
      cnt_done <= 1'b0;
      credit   <= 2'd1;
    end else begin
      credit <= credit + 2'(loc.loc_credit) - 2'(loc.loc_val);
      case (state)
        s_reset : state <= s_wait;
        s_wait  : state <= syn_val ? s_step1 : s_wait;
        s_step1 : state <= s_step2;
        s_step2 : state <= cnt_done ? s_hold : s_step1;
        // result kept until chien can latch it
        s_hold  : state <= loc.loc_val ? s_wait : s_hold;
        default : state <= s_wait;
      endcase
      // t iterations
      if (state == s_wait) begin
        cnt      <= cnt_w'(t);
        cnt_done <= 1'b0;
      end else if (state == s_step2) begin
        cnt      <= cnt - 1'b1;
        cnt_done <= (cnt == cnt_w'(2));
      end
    end
  end

  // ------------------------------
  // shared multipliers
  // ------------------------------

  // step1 sigma * lambda, step2 delta * zB
  always_comb begin
    for (int i = 0; i <= t; i++) begin
      if (state == s_step1) begin
        mult[i] = gf_mult_a_by_b(sigma, l_poly[i]);
      end else begin
        mult[i] = gf_mult_a_by_b(delta, b_poly[i-1]);
      end
    end
  end

  // discrepancy
  always_comb begin
    delta_c = '0;
    for (int j = 0; j <= t; j++) begin
      delta_c ^= gf_mult_a_by_b(l_poly[j], syn_reg[1-j]);
    end
  end

  // ------------------------------
  // iteration
  // ------------------------------

  always_ff @(posedge iclk) begin
    case (state)
      s_wait : begin
        for (int i = 1 - t; i <= 0; i++) begin
          syn_reg[i] <= '0;
        end
        for (int i = 1; i <= 2 * t; i++) begin
          syn_reg[i] <= syndrome[i];
        end
        if (syn_val) begin
          lat_ptr <= syn_ptr;
          for (int i = -1; i <= t; i++) begin
            l_poly[i] <= (i == 0) ? data_t'(1) : '0;
          end
        end
        for (int i = -2; i <= t; i++) begin
          b_poly[i] <= (i == 0) ? data_t'(1) : '0;
        end
        sigma <= data_t'(1);
        kv    <= '0;
      end
      s_step1 : begin
        delta <= delta_c;
        for (int i = 1 - t; i <= 2 * t - 2; i++) begin
          syn_reg[i] <= syn_reg[i+2];
        end
        for (int i = 0; i <= t; i++) begin
          l_poly_next[i] <= mult[i];
        end
      end
      s_step2 : begin
        for (int i = 0; i <= t; i++) begin
          l_poly[i] <= l_poly_next[i] ^ mult[i];
        end
        // B <- z * lambda or z^2 * B
        if ((delta != '0) && !kv[m-1]) begin
          for (int i = 0; i <= t; i++) begin
            b_poly[i] <= l_poly[i-1];
          end
          sigma <= delta;
          kv    <= -kv;
        end else begin
          for (int i = 0; i <= t; i++) begin
            b_poly[i] <= b_poly[i-2];
          end
          kv <= kv + 2'd2;
        end
      end
      default : begin
      end
    endcase
  end

  // ------------------------------
  // output
  // ------------------------------

  assign loc.loc_val = (state == s_hold) && (credit != '0);
  assign loc.loc_ptr = lat_ptr;

  always_comb begin
    for (int i = 0; i <= t; i++) begin
      loc.loc_poly[i] = l_poly[i];
    end
  end

  // chien returns at most the one credit it was given
  a_credit_max : assert property (@(posedge iclk) disable iff (ireset)
    credit <= 2'd1);

  // a credit only comes back once it has been spent
  a_credit_after_val : assert property (@(posedge iclk) disable iff (ireset)
    loc.loc_credit |-> (credit == '0));

endmodule

`default_nettype wire

// File: source/bch_chien_correct.sv
`default_nettype none

module bch_chien_correct #(
  parameter int n = bch_dec_pkg::bch_n,
  parameter int t = bch_dec_pkg::bch_t
) (
  input  logic         iclk,
  input  logic         ireset,
  bch_loc_if.dst       loc,
  bch_buf_if.requester rd,
  output logic         out_val,
  output logic         out_bit,
  output logic         out_last,
  output logic         out_decfail,
  output logic         in_credit
);

  import bch_gf_pkg::*;
  import bch_dec_pkg::*;

  localparam int addr_w = $clog2(n);
  localparam int cnt_w  = $clog2(n + 1);

  typedef enum logic [1:0] {
    s_idle,
    s_search,
    s_read
  } state_t;

  state_t state;

  // input latch
  loc_poly_t lat_poly;
  ptr_t      lat_ptr;
  logic      lat_full;
  logic      start;

  // lambda_i * alpha^(-i*p)
  data_t             step [0:t];
  data_t             step_sum;
  logic              is_root;
  logic [addr_w-1:0] pos;
  logic [n-1:0]      err_mask;
  logic [cnt_w-1:0]  root_cnt;
  logic [cnt_w-1:0]  deg;
  logic              dec_fail;

  // readout
  ptr_t              rd_slot;
  logic [addr_w-1:0] rd_addr;
  logic [addr_w-1:0] rd_addr_d;
  logic              rd_val_d;

  assign start          = (state == s_idle) && lat_full;
  assign loc.loc_credit = start;

  // ------------------------------
  // root search
  // ------------------------------

  always_comb begin
    step_sum = '0;
    for (int i = 0; i <= t; i++) begin
      step_sum ^= step[i];
    end
  end

  assign is_root = (step_sum == '0);

  // stepping keeps nonzero terms nonzero, degree is stable
  always_comb begin
    deg = '0;
    for (int i = 1; i <= t; i++) begin
      if (step[i] != '0) begin
        deg = cnt_w'(i);
      end
    end
  end

  assign dec_fail = (root_cnt != deg);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= s_idle;
      lat_full  <= 1'b0;
      pos       <= '0;
      root_cnt  <= '0;
      rd_addr   <= '0;
      rd_val_d  <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      if (loc.loc_val) begin
        lat_full <= 1'b1;
      end else if (start) begin
        lat_full <= 1'b0;
      end
      rd_val_d  <= rd.req && rd.gnt;
      // slot is empty once the last bit is out
      in_credit <= out_last;
      case (state)
        s_idle : begin
          if (start) begin
            state    <= s_search;
            pos      <= '0;
            root_cnt <= '0;
          end
        end
        s_search : begin
          root_cnt <= root_cnt + cnt_w'(is_root);
          pos      <= pos + 1'b1;
          if (pos == addr_w'(n - 1)) begin
            state   <= s_read;
            rd_addr <= addr_w'(n - 1);
          end
        end
        s_read : begin
          // waits on the writer while gnt is low
          if (rd.gnt) begin
            rd_addr <= rd_addr - 1'b1;
            if (rd_addr == '0) begin
              state <= s_idle;
            end
          end
        end
        default : state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (loc.loc_val) begin
      lat_poly <= loc.loc_poly;
      lat_ptr  <= loc.loc_ptr;
    end
    if (start) begin
      rd_slot <= lat_ptr;
      for (int i = 0; i <= t; i++) begin
        step[i] <= lat_poly[i];
      end
    end else if (state == s_search) begin
      for (int i = 0; i <= t; i++) begin
        step[i] <= gf_mult_a_by_b(step[i], gf_alpha_pow((2**gf_m - 1) - i));
      end
      // root at alpha^-p, error at bit p
      err_mask[pos] <= is_root;
    end
    rd_addr_d <= rd_addr;
  end

  // ------------------------------
  // corrected readout
  // ------------------------------

  assign rd.req   = (state == s_read);
  assign rd.we    = 1'b0;
  assign rd.slot  = rd_slot;
  assign rd.addr  = rd_addr;
  assign rd.wdata = 1'b0;

  // uncorrected on failure
  assign out_val     = rd_val_d;
  assign out_bit     = rd.rdata ^ (err_mask[rd_addr_d] & ~dec_fail);
  assign out_last    = rd_val_d && (rd_addr_d == '0);
  assign out_decfail = dec_fail;

  // every bit sent out comes from a written buffer cell
  a_rdata_known : assert property (@(posedge iclk) disable iff (ireset)
    out_val |-> !$isunknown(rd.rdata));

endmodule

`default_nettype wire

// File: source/bch_frame_buffer.sv
`default_nettype none

module bch_frame_buffer #(
  parameter int n = bch_dec_pkg::bch_n
) (
  input logic    iclk,
  input logic    ireset,
  bch_buf_if.mem wr,
  bch_buf_if.mem rd
);

  import bch_dec_pkg::*;

  // one bit per code position, per slot
  logic mem [0:bch_nslots-1][0:n-1];

  // ------------------------------
  // arbiter
  // ------------------------------

  // writer first, the reader can wait
  assign wr.gnt = wr.req;
  assign rd.gnt = rd.req && !wr.req;

  // ------------------------------
  // storage
  // ------------------------------

  // at most one grant, so one write per cycle
  always_ff @(posedge iclk) begin
    if (wr.gnt && wr.we) begin
      mem[wr.slot][wr.addr] <= wr.wdata;
    end else if (rd.gnt && rd.we) begin
      mem[rd.slot][rd.addr] <= rd.wdata;
    end
  end

  // registered read data per port
  always_ff @(posedge iclk) begin
    if (wr.gnt && !wr.we) begin
      wr.rdata <= mem[wr.slot][wr.addr];
    end
    if (rd.gnt && !rd.we) begin
      rd.rdata <= mem[rd.slot][rd.addr];
    end
  end

  // credits keep the writer off the slot still being read
  a_no_slot_clash : assert property (@(posedge iclk) disable iff (ireset)
    (wr.req && rd.req) |-> (wr.slot != rd.slot));

endmodule

`default_nettype wire

// File: source/bch_decoder_top.sv
`default_nettype none

module bch_decoder_top #(
  parameter int m      = bch_gf_pkg::gf_m,
  parameter int n      = bch_dec_pkg::bch_n,
  parameter int t      = bch_dec_pkg::bch_t,
  parameter int irrpol = bch_gf_pkg::gf_irrpol
) (
  input  logic iclk,
  input  logic ireset,
  input  logic in_val,
  input  logic in_bit,
  output logic in_credit,
  output logic out_val,
  output logic out_bit,
  output logic out_last,
  output logic out_decfail
);

  import bch_gf_pkg::*;
  import bch_dec_pkg::*;

  // field and code parameters must match the package tables
  if (m != gf_m || irrpol != gf_irrpol || n != bch_n || 2 * t != bch_t2) begin : g_param_check
    $error("bch_decoder_top: parameters differ from package constants");
  end

  logic  syn_val;
  ptr_t  syn_ptr;
  data_t syndrome [1:2*t];

  bch_loc_if          u_loc_if ();
  bch_buf_if #(.n(n)) u_wr_if ();
  bch_buf_if #(.n(n)) u_rd_if ();

  bch_syndrome #(.n(n), .t(t)) u_bch_syndrome (
    .iclk     (iclk),
    .ireset   (ireset),
    .in_val   (in_val),
    .in_bit   (in_bit),
    .syn_val  (syn_val),
    .syn_ptr  (syn_ptr),
    .syndrome (syndrome),
    .wr       (u_wr_if)
  );

  bch_berlekamp_ibm_2t #(.m(m), .t(t)) u_bch_berlekamp (
    .iclk     (iclk),
    .ireset   (ireset),
    .syn_val  (syn_val),
    .syn_ptr  (syn_ptr),
    .syndrome (syndrome),
    .loc      (u_loc_if)
  );

  bch_chien_correct #(.n(n), .t(t)) u_bch_chien (
    .iclk        (iclk),
    .ireset      (ireset),
    .loc         (u_loc_if),
    .rd          (u_rd_if),
    .out_val     (out_val),
    .out_bit     (out_bit),
    .out_last    (out_last),
    .out_decfail (out_decfail),
    .in_credit   (in_credit)
  );

  bch_frame_buffer #(.n(n)) u_bch_frame_buffer (
    .iclk   (iclk),
    .ireset (ireset),
    .wr     (u_wr_if),
    .rd     (u_rd_if)
  );

endmodule

`default_nettype wire

// File: dv/bch_decoder_tb.sv
`default_nettype none

module bch_decoder_tb;

  import bch_dec_pkg::*;

  // message width of BCH(15,5)
  localparam int msg_w = 5;
  // x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
  localparam logic [10:0] gen_poly = 11'b101_0011_0111;
  // 8 clean + 40 corrected + 16 back-to-back + 4 fixed patterns
  localparam int n_frames = 68;
  localparam int timeout_cycles = 200 * n_frames + 100;

  logic iclk;
  logic ireset;
  logic in_val;
  logic in_bit;
  logic in_credit;
  logic out_val;
  logic out_bit;
  logic out_last;
  logic out_decfail;

  // source side bookkeeping
  logic start_beat;
  int   credits = bch_nslots;
  int   frames_in = 0;
  int   frames_sent = 0;
  int   cycle_cnt = 0;

  // expected frames, oldest first
  logic [bch_n-1:0] exp_cw_q [$];
  int               exp_ne_q [$];

  // output side, sampled one edge later for the assertions
  int   out_idx = 0;
  int   frames_out = 0;
  int   credit_pulses = 0;
  logic chk_val;
  logic got_bit;
  logic want_bit;
  logic got_last;
  logic want_last;
  logic got_decfail;
  int   chk_frame;
  int   chk_idx;
  int   chk_ne;

  bch_decoder_top u_bch_decoder_top (
    .iclk        (iclk),
    .ireset      (ireset),
    .in_val      (in_val),
    .in_bit      (in_bit),
    .in_credit   (in_credit),
    .out_val     (out_val),
    .out_bit     (out_bit),
    .out_last    (out_last),
    .out_decfail (out_decfail)
  );

  initial begin
    iclk = 1'b0;
    forever begin
      #4 iclk = ~iclk;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------

  // systematic encoding, message in the top bits
  function automatic logic [bch_n-1:0] encode_codeword(input logic [msg_w-1:0] msg);
    logic [bch_n-1:0] rem;
    rem = {msg, 10'b0};
    for (int i = bch_n - 1; i >= 10; i--) begin
      if (rem[i]) begin
        rem ^= bch_n'(gen_poly) << (i - 10);
      end
    end
    return {msg, rem[9:0]};
  endfunction

  // n_err distinct flipped positions
  function automatic logic [bch_n-1:0] error_pattern(input int n_err);
    logic [bch_n-1:0] e;
    int               pos;
    e = '0;
    for (int k = 0; k < n_err; k++) begin
      pos = $urandom_range(bch_n - 1, 0);
      while (e[pos]) begin
        pos = $urandom_range(bch_n - 1, 0);
      end
      e[pos] = 1'b1;
    end
    return e;
  endfunction

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  // random idle cycles between beats
  task automatic insert_gap(input int gap_pct);
    int len;
    if ($urandom_range(99, 0) < gap_pct) begin
      len = $urandom_range(3, 1);
      repeat (len) begin
        @(posedge iclk);
        #1;
      end
    end
  endtask

  // highest degree bit goes first
  task automatic send_frame(input logic [bch_n-1:0] rx, input logic [bch_n-1:0] cw,
                            input int n_err, input int gap_pct);
    for (int i = bch_n - 1; i >= 0; i--) begin
      insert_gap(gap_pct);
      if (i == bch_n - 1) begin
        // a frame starts only on a held credit
        while (credits == 0) begin
          @(posedge iclk);
          #1;
        end
        exp_cw_q.push_back(cw);
        exp_ne_q.push_back(n_err);
        frames_in++;
        start_beat = 1'b1;
      end
      in_val = 1'b1;
      in_bit = rx[i];
      @(posedge iclk);
      #1;
      in_val     = 1'b0;
      start_beat = 1'b0;
    end
    frames_sent++;
  endtask

  task automatic run_frame(input logic [msg_w-1:0] msg, input int n_err, input int gap_pct);
    logic [bch_n-1:0] cw;
    logic [bch_n-1:0] err;
    cw  = encode_codeword(msg);
    err = error_pattern(n_err);
    send_frame(cw ^ err, cw, n_err, gap_pct);
  endtask

  // spent on a first beat, returned by in_credit
  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      credits <= bch_nslots;
    end else begin
      credits <= credits + int'(in_credit) - int'(start_beat);
    end
  end

  // ------------------------------
  // scoreboard
  // ------------------------------

  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      chk_val       <= 1'b0;
      out_idx       <= 0;
      frames_out    <= 0;
      credit_pulses <= 0;
    end else begin
      chk_val <= out_val;
      if (in_credit) begin
        credit_pulses <= credit_pulses + 1;
      end
      if (out_val) begin
        got_bit     <= out_bit;
        got_last    <= out_last;
        got_decfail <= out_decfail;
        want_last   <= (out_idx == bch_n - 1);
        chk_frame   <= frames_out;
        chk_idx     <= out_idx;
        if (exp_cw_q.size() != 0) begin
          want_bit <= exp_cw_q[0][bch_n-1-out_idx];
          chk_ne   <= exp_ne_q[0];
        end
        // frame done after n bits, next one in arrival order
        if (out_idx == bch_n - 1) begin
          out_idx    <= 0;
          frames_out <= frames_out + 1;
          void'(exp_cw_q.pop_front());
          void'(exp_ne_q.pop_front());
        end else begin
          out_idx <= out_idx + 1;
        end
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_out_bit : assert property (@(posedge iclk) disable iff (ireset)
    chk_val |-> (got_bit == want_bit))
    else begin
      $display("MISMATCH time=%0t out_bit frame %0d bit %0d (%0d errors): got %0b expected %0b",
               $time, $sampled(chk_frame), $sampled(chk_idx), $sampled(chk_ne),
               $sampled(got_bit), $sampled(want_bit));
      abort_run();
    end

  a_out_last : assert property (@(posedge iclk) disable iff (ireset)
    chk_val |-> (got_last == want_last))
    else begin
      $display("MISMATCH time=%0t out_last frame %0d beat %0d: got %0b expected %0b",
               $time, $sampled(chk_frame), $sampled(chk_idx),
               $sampled(got_last), $sampled(want_last));
      abort_run();
    end

  // at most t errors, never a failure
  a_out_decfail : assert property (@(posedge iclk) disable iff (ireset)
    (chk_val && want_last) |-> !got_decfail)
    else begin
      $display("MISMATCH time=%0t out_decfail frame %0d: got %0b expected 0",
               $time, $sampled(chk_frame), $sampled(got_decfail));
      abort_run();
    end

  a_last_with_val : assert property (@(posedge iclk) disable iff (ireset)
    out_last |-> out_val)
    else begin
      $display("out_last was high without out_val at time %0t", $time);
      abort_run();
    end

  a_no_orphan : assert property (@(posedge iclk) disable iff (ireset)
    out_val |-> (frames_out < frames_in))
    else begin
      $display("output bit at time %0t with no frame pending", $time);
      abort_run();
    end

  // nothing leaves before the first full frame is in
  a_quiet_start : assert property (@(posedge iclk) disable iff (ireset)
    (frames_sent == 0) |-> !(out_val || out_last || in_credit))
    else begin
      $display("output activity at time %0t before the first frame was complete", $time);
      abort_run();
    end

  a_credit_after_last : assert property (@(posedge iclk) disable iff (ireset)
    out_last |=> in_credit)
    else begin
      $display("no in_credit pulse after out_last at time %0t", $time);
      abort_run();
    end

  a_credit_only_after_last : assert property (@(posedge iclk) disable iff (ireset)
    in_credit |-> $past(out_last))
    else begin
      $display("in_credit pulsed at time %0t without a delivered frame", $time);
      abort_run();
    end

  a_credit_range : assert property (@(posedge iclk) disable iff (ireset)
    (credits >= 0) && (credits <= bch_nslots))
    else begin
      $display("source credit count %0d out of range at time %0t", $sampled(credits), $time);
      abort_run();
    end

  // ------------------------------
  // watchdog and main sequence
  // ------------------------------

  initial begin
    while (cycle_cnt < timeout_cycles) begin
      @(posedge iclk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d of %0d frames out",
             timeout_cycles, frames_out, n_frames);
    abort_run();
  end

  initial begin
    void'($urandom(22674));
    ireset     = 1'b1;
    in_val     = 1'b0;
    in_bit     = 1'b0;
    start_beat = 1'b0;
    repeat (10) @(posedge iclk);
    #1;
    ireset = 1'b0;
    repeat (5) begin
      @(posedge iclk);
      #1;
    end

    // clean codewords
    repeat (8) begin
      run_frame(msg_w'($urandom_range(2**msg_w - 1, 0)), 0, 30);
    end
    // 0 to 3 errors, every count in turn
    for (int k = 0; k < 40; k++) begin
      run_frame(msg_w'($urandom_range(2**msg_w - 1, 0)), k % 4, 30);
    end
    // no gaps at all, limited only by credits
    repeat (16) begin
      run_frame(msg_w'($urandom_range(2**msg_w - 1, 0)), $urandom_range(bch_t, 0), 0);
    end
    // all zeros and all ones under heavy gaps
    run_frame('0, 0, 50);
    run_frame('1, 0, 50);
    run_frame('1, 0, 50);
    run_frame('0, 0, 50);

    wait (frames_out == n_frames);
    repeat (4) begin
      @(posedge iclk);
      #1;
    end

    if (credits == bch_nslots && credit_pulses == n_frames && exp_cw_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("run ended with %0d credits, %0d credit pulses, %0d frames pending",
               credits, credit_pulses, exp_cw_q.size());
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: bch_decoder.f
source/bch_gf_pkg.sv
source/bch_dec_pkg.sv
source/bch_loc_if.sv
source/bch_buf_if.sv
source/bch_syndrome.sv
source/bch_berlekamp_ibm_2t.sv
source/bch_chien_correct.sv
source/bch_frame_buffer.sv
source/bch_decoder_top.sv
dv/bch_decoder_tb.sv
